//--- Bender.yml
package:
  name: ctrl_unit

sources:
  - include_dirs:
      - include
    files:
      - hw/cpuIsaPkg.sv
      - hw/ctrlSigPkg.sv
      - hw/instrDecoder.sv
      - hw/irqArbiter.sv
      - hw/ctrlSequencer.sv
      - hw/ctrlDecoder.sv
      - hw/ctrlTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ctrlChecker.sv
      - dv/ctrlTb.sv

//--- dv/ctrlChecker.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module ctrlChecker import cpuIsaPkg::*, ctrlSigPkg::*; (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic [`CTRL_INSTR_W-1:0] instrWord,
    input  aluFlags_t                flags,
    input  logic                     interruptEnable,
    input  logic [`CTRL_NUM_IRQ-1:0] irqReq,
    input  regFileCtrl_t             regFile,
    input  aluCtrl_t                 alu,
    input  dMemCtrl_t                dMem,
    input  statusCtrl_t              status,
    input  fetchCtrl_t               fetch,
    input  logic [`CTRL_INSTR_W-1:0] irqVector,
    input  logic [`CTRL_NUM_IRQ-1:0] irqClr,
    output int                       errCount,
    output int                       checkCount
);

    localparam logic [3:0] spReg = `CTRL_SP_LO_REG;

    ctrlState_e mState;
    ctrlState_e mNext;
    int         mCnt;

    initial begin
        errCount   = 0;
        checkCount = 0;
    end

    //**********************************************************
    // instruction set rules
    function automatic instrClass_e classify(input logic [15:0] w);
        logic [4:0] op;
        op = w[7:3];
        if (w[0] && w[3:1] != 3'b111) return ALU_IMM;
        if (w[2:0] == 3'b010) return IO_IN;
        if (w[2:0] == 3'b100) return IO_OUT;
        if (w[2:0] != 3'b000) return NOP;
        if (op >= 5'd1 && op <= 5'd12) return ALU_REG;
        if (op == 5'd22) return JUMP;
        if (op == 5'd23) return CALL;
        if (op == 5'd24) return RET;
        if (op == 5'd29) return HALT;
        return NOP;
    endfunction

    function automatic logic condHolds(input logic [2:0] cc, input aluFlags_t f);
        case (cc)
            3'd1:    return f.carry;
            3'd2:    return !f.carry;
            3'd3:    return f.zero;
            3'd4:    return !f.zero;
            3'd5:    return f.negative;
            3'd6:    return !f.negative;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [15:0] vectorFor(input logic [2:0] req);
        if (req[0]) return 16'(`CTRL_IRQ_VEC0);
        if (req[1]) return 16'(`CTRL_IRQ_VEC1);
        if (req[2]) return 16'(`CTRL_IRQ_VEC2);
        return 16'd0;
    endfunction

    task automatic checkField(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        checkCount++;
        if (act !== exp) begin
            errCount++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    // model state, same reset as the sequencer
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mState <= START;
            mCnt   <= 0;
        end else begin
            mState <= mNext;
            mCnt   <= (mState == START) ? mCnt + 1 : 0;
        end
    end

    //**********************************************************
    // expected control word, sampled mid-cycle
    always @(negedge clk) begin : modelCompare
        instrClass_e  cls;
        logic         met;
        regFileCtrl_t eRf;
        aluCtrl_t     eAlu;
        dMemCtrl_t    eMem;
        statusCtrl_t  eStat;
        fetchCtrl_t   eFetch;
        logic [2:0]   eClr;

        cls    = classify(instrWord);
        met    = condHolds(instrWord[15:13], flags);
        eRf    = '{REG_SRC_ALU, instrWord[15:12], 1'b0, 1'b0, 1'b0};
        eAlu   = '{ALUB_REG, 4'd0};
        eMem   = '{DDATA_ALU, DADDR_SP, 1'b0, 1'b0};
        eStat  = '{STAT_ALU_FLAGS, 1'b0};
        eFetch = '{FETCH_PC, 1'b1, 1'b1}; // plain advance
        eClr   = 3'b000;
        mNext  = PART1;

        case (mState)
            START: begin
                eStat            = '{STAT_IRQ_DIS, 1'b1};
                eFetch.pcWriteEn = (mCnt == `CTRL_STARTUP_DELAY);
                mNext            = eFetch.pcWriteEn ? PART1 : START;
            end
            IRQ_ENTRY: begin
                eRf.outBSelect    = spReg;
                eRf.decPair       = 1'b1;
                eMem.dataSelect   = DDATA_PC_HI;
                eMem.writeEn      = 1'b1;
                eStat             = '{STAT_IRQ_DIS, 1'b1};
                eFetch.addrSelect = FETCH_IRQ_VEC;
                eClr              = irqReq & (~irqReq + 3'd1); // lowest set bit
            end
            JMP_ADDR: eFetch.addrSelect = FETCH_INSTR;
            CALL_ADDR: begin
                eRf.outBSelect    = spReg;
                eRf.decPair       = 1'b1;
                eMem.dataSelect   = DDATA_PCP1_HI;
                eMem.writeEn      = 1'b1;
                eFetch.addrSelect = FETCH_INSTR;
            end
            PART2: begin
                if (cls == IO_IN) begin
                    eRf.src         = REG_SRC_IO;
                    eRf.writeEnable = 1'b1;
                    eMem.addrSelect = DADDR_PORT;
                    eMem.readEn     = 1'b1;
                end else if (cls == RET) begin
                    eRf.outBSelect    = spReg;
                    eRf.incPair       = 1'b1; // second pop
                    eMem.addrSelect   = DADDR_SP_P1;
                    eMem.readEn       = 1'b1;
                    eFetch            = '{FETCH_RET_ADDR, 1'b0, 1'b0};
                    mNext             = PART3;
                end
            end
            PART3: begin
                eRf.outBSelect    = spReg;
                eMem.addrSelect   = DADDR_SP_P1;
                eMem.readEn       = 1'b1;
                eFetch.addrSelect = FETCH_RET_ADDR;
            end
            default: begin
                if (interruptEnable && irqReq != 3'b000) begin
                    eRf.outBSelect  = spReg;
                    eRf.decPair     = 1'b1;
                    eMem.dataSelect = DDATA_PC_LO;
                    eMem.writeEn    = 1'b1;
                    eStat           = '{STAT_IRQ_DIS, 1'b1};
                    eFetch          = '{FETCH_IRQ_VEC, 1'b0, 1'b0};
                    mNext           = IRQ_ENTRY;
                end else begin
                    case (cls)
                        ALU_IMM: begin
                            eRf.writeEnable = 1'b1;
                            eAlu            = '{ALUB_IMM, {1'b0, instrWord[3:1]}};
                            eStat.flagEnable = (instrWord[3:1] != 3'b000);
                        end
                        ALU_REG: begin
                            eRf.outBSelect   = instrWord[11:8];
                            eRf.writeEnable  = 1'b1;
                            eAlu.mode        = instrWord[6:3];
                            eStat.flagEnable = 1'b1;
                        end
                        IO_IN: begin
                            eRf.src         = REG_SRC_IO;
                            eMem.addrSelect = DADDR_PORT;
                            eMem.readEn     = 1'b1;
                            eFetch          = '{FETCH_PC, 1'b0, 1'b0};
                            mNext           = PART2;
                        end
                        IO_OUT: begin
                            eMem.addrSelect = DADDR_PORT;
                            eMem.writeEn    = 1'b1;
                        end
                        JUMP: begin
                            if (met) begin
                                mNext = JMP_ADDR;
                            end else begin
                                eFetch.addrSelect = FETCH_PC_P1;
                            end
                        end
                        CALL: begin
                            eRf.outBSelect  = spReg;
                            eMem.dataSelect = DDATA_PCP1_LO;
                            if (met) begin
                                eRf.decPair      = 1'b1;
                                eMem.writeEn     = 1'b1;
                                eFetch.pcWriteEn = 1'b0;
                                mNext            = CALL_ADDR;
                            end else begin
                                eFetch.addrSelect = FETCH_PC_P1;
                            end
                        end
                        RET: begin
                            eRf.outBSelect  = spReg;
                            eMem.addrSelect = DADDR_SP_P1;
                            if (met) begin
                                eRf.incPair = 1'b1; // first pop
                                eMem.readEn = 1'b1;
                                eFetch      = '{FETCH_RET_ADDR, 1'b0, 1'b0};
                                mNext       = PART2;
                            end
                        end
                        HALT: eFetch = '{FETCH_PC, 1'b0, 1'b0};
                        default: begin
                        end
                    endcase
                end
            end
        endcase

        checkField("regFile.src", eRf.src, regFile.src);
        checkField("regFile.outBSelect", eRf.outBSelect, regFile.outBSelect);
        checkField("regFile.writeEnable", eRf.writeEnable, regFile.writeEnable);
        checkField("regFile.incPair", eRf.incPair, regFile.incPair);
        checkField("regFile.decPair", eRf.decPair, regFile.decPair);
        checkField("alu.srcBSelect", eAlu.srcBSelect, alu.srcBSelect);
        checkField("alu.mode", eAlu.mode, alu.mode);
        checkField("dMem.dataSelect", eMem.dataSelect, dMem.dataSelect);
        checkField("dMem.addrSelect", eMem.addrSelect, dMem.addrSelect);
        checkField("dMem.writeEn", eMem.writeEn, dMem.writeEn);
        checkField("dMem.readEn", eMem.readEn, dMem.readEn);
        checkField("status.srcSelect", eStat.srcSelect, status.srcSelect);
        checkField("status.flagEnable", eStat.flagEnable, status.flagEnable);
        checkField("fetch.addrSelect", eFetch.addrSelect, fetch.addrSelect);
        checkField("fetch.readEnable", eFetch.readEnable, fetch.readEnable);
        checkField("fetch.pcWriteEn", eFetch.pcWriteEn, fetch.pcWriteEn);
        checkField("irqVector", vectorFor(irqReq), irqVector);
        checkField("irqClr", eClr, irqClr);
    end

endmodule

//--- dv/ctrlTb.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module ctrlTb import ctrlSigPkg::*;;

    localparam int resetCycles    = 16;
    localparam int randomCycles   = 2000;
    localparam int watchdogCycles = randomCycles + resetCycles + 41 + 200;

    logic                     clk;
    logic                     arstN;
    logic [`CTRL_INSTR_W-1:0] instrWord;
    aluFlags_t                flags;
    logic                     interruptEnable;
    logic [`CTRL_NUM_IRQ-1:0] irqReq;
    regFileCtrl_t             regFile;
    aluCtrl_t                 alu;
    dMemCtrl_t                dMem;
    statusCtrl_t              status;
    fetchCtrl_t               fetch;
    logic [`CTRL_INSTR_W-1:0] irqVector;
    logic [`CTRL_NUM_IRQ-1:0] irqClr;
    int                       errCount;
    int                       checkCount;
    logic                     fetchSeen; // readEnable before the coming edge
    logic                     halted;

    ctrlTop u_dut (
        .clk             (clk),
        .arstN           (arstN),
        .instrWord       (instrWord),
        .flags           (flags),
        .interruptEnable (interruptEnable),
        .irqReq          (irqReq),
        .regFile         (regFile),
        .alu             (alu),
        .dMem            (dMem),
        .status          (status),
        .fetch           (fetch),
        .irqVector       (irqVector),
        .irqClr          (irqClr)
    );

    ctrlChecker u_checker (
        .clk             (clk),
        .arstN           (arstN),
        .instrWord       (instrWord),
        .flags           (flags),
        .interruptEnable (interruptEnable),
        .irqReq          (irqReq),
        .regFile         (regFile),
        .alu             (alu),
        .dMem            (dMem),
        .status          (status),
        .fetch           (fetch),
        .irqVector       (irqVector),
        .irqClr          (irqClr),
        .errCount        (errCount),
        .checkCount      (checkCount)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(negedge clk) begin
        fetchSeen = fetch.readEnable;
    end

    //**********************************************************
    // weighted instruction words
    task automatic pickWord(output logic [15:0] w, output logic halt);
        int sel;
        w    = 16'($urandom);
        halt = 1'b0;
        sel  = $urandom_range(0, 99);
        if (sel < 20) begin
            w[0] = 1'b1;
            if (w[3:1] == 3'b111) begin
                w[3:1] = 3'b000; // load immediate
            end
        end else if (sel < 40) begin
            w[2:0] = 3'b000;
            w[7:3] = 5'($urandom_range(1, 12));
        end else if (sel < 48) begin
            w[2:0] = 3'b010;
        end else if (sel < 56) begin
            w[2:0] = 3'b100;
        end else if (sel < 86) begin
            w[2:0] = 3'b000;
            w[7:3] = 5'd22 + 5'($urandom_range(0, 2)); // JMP, CALL or RET
        end else if (sel < 90) begin
            w[2:0] = 3'b000;
            w[7:3] = 5'd29;
            halt   = 1'b1;
        end else begin
            w[2:0] = 3'b000; // dropped pair and status opcodes
            w[7:3] = 5'($urandom_range(13, 21));
            if (sel >= 95) begin
                w[3:0] = 4'hF;
            end
        end
    endtask

    initial begin
        logic [15:0] nextWord;
        logic        nextHalt;

        void'($urandom(69));
        arstN           = 1'b0;
        instrWord       = 16'h0000;
        flags           = '0;
        interruptEnable = 1'b0;
        irqReq          = '0;
        halted          = 1'b0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;

        for (int cyc = 0; cyc < randomCycles; cyc++) begin
            @(posedge clk);
            flags <= aluFlags_t'($urandom_range(0, 7));
            if (fetchSeen) begin
                pickWord(nextWord, nextHalt);
                instrWord <= nextWord;
                halted    = nextHalt;
            end
            if (halted && $urandom_range(0, 3) == 0) begin
                interruptEnable <= 1'b1; // wake the halted core
                irqReq          <= 3'($urandom_range(1, 7));
            end else begin
                interruptEnable <= 1'($urandom_range(0, 1));
                irqReq <= ($urandom_range(0, 5) == 0) ? 3'($urandom_range(1, 7)) : 3'b000;
            end
        end
        repeat (2) @(posedge clk);

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdogCycles * 10);
        $display("watchdog expired before the random test finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- hw/cpuIsaPkg.sv
package cpuIsaPkg;

    // instruction classes the control decoder acts on
    typedef enum logic [3:0] {
        ALU_IMM = 4'd0,
        ALU_REG = 4'd1,
        IO_IN   = 4'd2,
        IO_OUT  = 4'd3,
        JUMP    = 4'd4,
        CALL    = 4'd5,
        RET     = 4'd6,
        HALT    = 4'd7,
        NOP     = 4'd8
    } instrClass_e;

    // condition field, bits 15..13 of the word
    typedef enum logic [2:0] {
        COND_ALWAYS  = 3'd0,
        COND_C       = 3'd1,
        COND_NC      = 3'd2,
        COND_Z       = 3'd3,
        COND_NZ      = 3'd4,
        COND_N       = 3'd5,
        COND_NN      = 3'd6,
        COND_ALWAYS7 = 3'd7
    } condCode_e;

    typedef struct packed {
        instrClass_e cls;
        logic        condMet;    // branch condition holds
        logic [3:0]  aluMode;
        logic [3:0]  regB;       // source register field, bits 11..8
        logic        setsFlags;
    } decodedInstr_t;

endpackage : cpuIsaPkg

//--- hw/ctrlDecoder.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module ctrlDecoder import cpuIsaPkg::*, ctrlSigPkg::*; (
    input  ctrlState_e               state,
    input  logic                     delayDone,
    input  decodedInstr_t            decoded,
    input  logic                     irqPending,
    input  logic                     interruptEnable,
    input  logic [`CTRL_INSTR_W-1:0] instrWord,
    output regFileCtrl_t             regFile,
    output aluCtrl_t                 alu,
    output dMemCtrl_t                dMem,
    output statusCtrl_t              status,
    output fetchCtrl_t               fetch,
    output ctrlState_e               nextState
);

    localparam logic [3:0] spLoReg = `CTRL_SP_LO_REG;

    always_comb begin
        //**********************************************************
        // NOP defaults, advance the PC
        regFile   = '{src: REG_SRC_ALU, outBSelect: instrWord[15:12], writeEnable: 1'b0,
                      incPair: 1'b0, decPair: 1'b0};
        alu       = '{srcBSelect: ALUB_REG, mode: 4'd0};
        dMem      = '{dataSelect: DDATA_ALU, addrSelect: DADDR_SP, writeEn: 1'b0, readEn: 1'b0};
        status    = '{srcSelect: STAT_ALU_FLAGS, flagEnable: 1'b0};
        fetch     = '{addrSelect: FETCH_PC, readEnable: 1'b1, pcWriteEn: 1'b1};
        nextState = PART1;

        case (state)
            START: begin
                status.srcSelect  = STAT_IRQ_DIS; // interrupts off until software enables
                status.flagEnable = 1'b1;
                fetch.pcWriteEn   = delayDone;
                nextState         = delayDone ? PART1 : START;
            end
            IRQ_ENTRY: begin
                regFile.outBSelect = spLoReg;
                regFile.decPair    = 1'b1;
                dMem.dataSelect    = DDATA_PC_HI;  // high return byte
                dMem.writeEn       = 1'b1;
                status.srcSelect   = STAT_IRQ_DIS;
                status.flagEnable  = 1'b1;
                fetch.addrSelect   = FETCH_IRQ_VEC;
            end
            JMP_ADDR: begin
                fetch.addrSelect = FETCH_INSTR;  // target is the current word
            end
            CALL_ADDR: begin
                regFile.outBSelect = spLoReg;
                regFile.decPair    = 1'b1;
                dMem.dataSelect    = DDATA_PCP1_HI;
                dMem.writeEn       = 1'b1;
                fetch.addrSelect   = FETCH_INSTR;
            end
            default: begin
                if (state == PART1 && interruptEnable && irqPending) begin
                    // entry beats the instruction, push low byte first
                    regFile.outBSelect = spLoReg;
                    regFile.decPair    = 1'b1;
                    dMem.dataSelect    = DDATA_PC_LO;
                    dMem.writeEn       = 1'b1;
                    status.srcSelect   = STAT_IRQ_DIS;
                    status.flagEnable  = 1'b1;
                    fetch.addrSelect   = FETCH_IRQ_VEC;
                    fetch.readEnable   = 1'b0;
                    fetch.pcWriteEn    = 1'b0;
                    nextState          = IRQ_ENTRY;
                end else begin
                    case (decoded.cls)
                        ALU_IMM: begin
                            regFile.writeEnable = 1'b1;
                            alu.srcBSelect      = ALUB_IMM;
                            alu.mode            = decoded.aluMode;
                            status.flagEnable   = decoded.setsFlags;
                        end
                        ALU_REG: begin
                            regFile.outBSelect  = decoded.regB;
                            regFile.writeEnable = 1'b1;
                            alu.mode            = decoded.aluMode;
                            status.flagEnable   = decoded.setsFlags;
                        end
                        IO_IN: begin
                            regFile.src     = REG_SRC_IO;
                            dMem.addrSelect = DADDR_PORT;
                            dMem.readEn     = 1'b1;
                            if (state == PART1) begin
                                fetch.readEnable = 1'b0; // wait for read data
                                fetch.pcWriteEn  = 1'b0;
                                nextState        = PART2;
                            end else begin
                                regFile.writeEnable = 1'b1;
                            end
                        end
                        IO_OUT: begin
                            dMem.addrSelect = DADDR_PORT;
                            dMem.writeEn    = 1'b1;
                        end
                        JUMP: begin
                            if (decoded.condMet) begin
                                nextState = JMP_ADDR; // fetch address word
                            end else begin
                                fetch.addrSelect = FETCH_PC_P1; // skip address word
                            end
                        end
                        CALL: begin
                            regFile.outBSelect = spLoReg;
                            dMem.dataSelect    = DDATA_PCP1_LO;
                            if (decoded.condMet) begin
                                regFile.decPair = 1'b1;
                                dMem.writeEn    = 1'b1;
                                fetch.pcWriteEn = 1'b0; // PC kept for high byte push
                                nextState       = CALL_ADDR;
                            end else begin
                                fetch.addrSelect = FETCH_PC_P1;
                            end
                        end
                        RET: begin
                            regFile.outBSelect = spLoReg;
                            dMem.addrSelect    = DADDR_SP_P1;
                            if (state == PART3) begin
                                dMem.readEn      = 1'b1;
                                fetch.addrSelect = FETCH_RET_ADDR;
                            end else if (state == PART2 || decoded.condMet) begin
                                regFile.incPair  = 1'b1; // pop one byte
                                dMem.readEn      = 1'b1;
                                fetch.addrSelect = FETCH_RET_ADDR;
                                fetch.readEnable = 1'b0;
                                fetch.pcWriteEn  = 1'b0;
                                nextState        = (state == PART1) ? PART2 : PART3;
                            end
                        end
                        HALT: begin
                            fetch.readEnable = 1'b0; // hold until interrupt entry
                            fetch.pcWriteEn  = 1'b0;
                        end
                        default: begin
                        end
                    endcase
                end
            end
        endcase
    end

    dMemExcl: assert final (!(dMem.writeEn === 1'b1 && dMem.readEn === 1'b1))
        else $error("data memory read and write enabled together");

endmodule

//--- hw/ctrlSequencer.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module ctrlSequencer import ctrlSigPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  ctrlState_e nextState,
    output ctrlState_e state,
    output logic       delayDone,
    output logic       inIrqEntry
);

    localparam int cntW = $clog2(`CTRL_STARTUP_DELAY + 1);

    logic [cntW-1:0] delayCnt;

    //**********************************************************
    // state register and start-up counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= START;
            delayCnt <= '0;
        end else begin
            state <= nextState;
            if (state == START) begin
                delayCnt <= delayCnt + 1'b1;
            end else begin
                delayCnt <= '0;
            end
        end
    end

    assign delayDone  = (delayCnt == cntW'(`CTRL_STARTUP_DELAY));
    assign inIrqEntry = (state == IRQ_ENTRY);

    // START is only reachable through reset
    noReStart: assert property (@(posedge clk) disable iff (!arstN)
        (state != START) |=> (state != START))
        else $error("sequencer re-entered START without reset");

endmodule

//--- hw/ctrlSigPkg.sv
package ctrlSigPkg;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } aluFlags_t;

    //**********************************************************
    // select encodings seen by the datapath
    typedef enum logic [1:0] {
        REG_SRC_ALU = 2'b00,
        REG_SRC_IO  = 2'b10
    } regSrc_e;

    typedef enum logic [1:0] {
        ALUB_REG = 2'b00,
        ALUB_IMM = 2'b10     // immediate byte
    } aluBSel_e;

    typedef enum logic [2:0] {
        DDATA_PCP1_HI = 3'b000,
        DDATA_PCP1_LO = 3'b001,
        DDATA_ALU     = 3'b010,
        DDATA_PC_HI   = 3'b011,
        DDATA_PC_LO   = 3'b100
    } dMemData_e;

    typedef enum logic [1:0] {
        DADDR_SP    = 2'b00, // stack pointer pair
        DADDR_PORT  = 2'b01, // port immediate
        DADDR_SP_P1 = 2'b10
    } dMemAddr_e;

    typedef enum logic [1:0] {
        STAT_ALU_FLAGS = 2'b00,
        STAT_IRQ_DIS   = 2'b11 // keep flags, clear interrupt enable
    } statusSrc_e;

    typedef enum logic [2:0] {
        FETCH_PC_P1    = 3'b000,
        FETCH_PC       = 3'b001,
        FETCH_IRQ_VEC  = 3'b010,
        FETCH_INSTR    = 3'b011, // address word just fetched
        FETCH_RET_ADDR = 3'b101
    } fetchSel_e;

    //**********************************************************
    // per-unit control words
    typedef struct packed {
        regSrc_e    src;
        logic [3:0] outBSelect;
        logic       writeEnable;
        logic       incPair;
        logic       decPair;
    } regFileCtrl_t;

    typedef struct packed {
        aluBSel_e   srcBSelect;
        logic [3:0] mode;
    } aluCtrl_t;

    typedef struct packed {
        dMemData_e dataSelect;
        dMemAddr_e addrSelect;
        logic      writeEn;
        logic      readEn;
    } dMemCtrl_t;

    typedef struct packed {
        statusSrc_e srcSelect;
        logic       flagEnable;
    } statusCtrl_t;

    typedef struct packed {
        fetchSel_e addrSelect;
        logic      readEnable;
        logic      pcWriteEn;
    } fetchCtrl_t;

    typedef enum logic [2:0] {
        PART1     = 3'b000,
        PART2     = 3'b010,
        PART3     = 3'b100,
        JMP_ADDR  = 3'b001,
        CALL_ADDR = 3'b011,
        IRQ_ENTRY = 3'b101,
        START     = 3'b111
    } ctrlState_e;

endpackage : ctrlSigPkg

//--- hw/ctrlTop.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module ctrlTop import cpuIsaPkg::*, ctrlSigPkg::*; (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic [`CTRL_INSTR_W-1:0] instrWord,
    input  aluFlags_t                flags,
    input  logic                     interruptEnable,
    input  logic [`CTRL_NUM_IRQ-1:0] irqReq,
    output regFileCtrl_t             regFile,
    output aluCtrl_t                 alu,
    output dMemCtrl_t                dMem,
    output statusCtrl_t              status,
    output fetchCtrl_t               fetch,
    output logic [`CTRL_INSTR_W-1:0] irqVector,
    output logic [`CTRL_NUM_IRQ-1:0] irqClr
);

    decodedInstr_t decoded;
    ctrlState_e    state;
    ctrlState_e    nextState;
    logic          delayDone;
    logic          irqPending;
    logic          inIrqEntry;

    instrDecoder u_instrDecoder (
        .instrWord (instrWord),
        .flags     (flags),
        .decoded   (decoded)
    );

    irqArbiter u_irqArbiter (
        .irqReq     (irqReq),
        .inIrqEntry (inIrqEntry),
        .irqPending (irqPending),
        .irqVector  (irqVector),
        .irqClr     (irqClr)
    );

    ctrlSequencer u_ctrlSequencer (
        .clk        (clk),
        .arstN      (arstN),
        .nextState  (nextState),
        .state      (state),
        .delayDone  (delayDone),
        .inIrqEntry (inIrqEntry)
    );

    ctrlDecoder u_ctrlDecoder (
        .state           (state),
        .delayDone       (delayDone),
        .decoded         (decoded),
        .irqPending      (irqPending),
        .interruptEnable (interruptEnable),
        .instrWord       (instrWord),
        .regFile         (regFile),
        .alu             (alu),
        .dMem            (dMem),
        .status          (status),
        .fetch           (fetch),
        .nextState       (nextState)
    );

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module instrDecoder import cpuIsaPkg::*, ctrlSigPkg::*; (
    input  logic [`CTRL_INSTR_W-1:0] instrWord,
    input  aluFlags_t                flags,
    output decodedInstr_t            decoded
);

    condCode_e  cond;
    logic       condMet;
    logic [4:0] opField;

    assign cond    = condCode_e'(instrWord[15:13]);
    assign opField = instrWord[7:3];

    always_comb begin
        case (cond)
            COND_C:  condMet = flags.carry;
            COND_NC: condMet = ~flags.carry;
            COND_Z:  condMet = flags.zero;
            COND_NZ: condMet = ~flags.zero;
            COND_N:  condMet = flags.negative;
            COND_NN: condMet = ~flags.negative;
            default: condMet = 1'b1; // codes 0 and 7
        endcase
    end

    //**********************************************************
    // classification, first match wins
    always_comb begin
        decoded.cls       = NOP;
        decoded.condMet   = condMet;
        decoded.aluMode   = 4'd0;
        decoded.regB      = instrWord[11:8];
        decoded.setsFlags = 1'b0;
        if (instrWord[0] && instrWord[3:1] != 3'b111) begin
            decoded.cls       = ALU_IMM;
            decoded.aluMode   = {1'b0, instrWord[3:1]};
            decoded.setsFlags = (instrWord[3:1] != 3'b000); // LDI leaves flags
        end else if (instrWord[2:0] == 3'b010) begin
            decoded.cls = IO_IN;
        end else if (instrWord[2:0] == 3'b100) begin
            decoded.cls = IO_OUT;
        end else if (instrWord[2:0] == 3'b000) begin
            case (opField) inside
                [5'd1:5'd12]: begin
                    decoded.cls       = ALU_REG;
                    decoded.aluMode   = instrWord[6:3];
                    decoded.setsFlags = 1'b1;
                end
                5'd22:   decoded.cls = JUMP;
                5'd23:   decoded.cls = CALL;
                5'd24:   decoded.cls = RET;
                5'd29:   decoded.cls = HALT;
                default: decoded.cls = NOP; // includes dropped pair/status ops
            endcase
        end
    end

    clsKnown: assert final ($isunknown(instrWord) || !$isunknown(decoded.cls))
        else $error("instruction class unknown for a known word");

endmodule

//--- hw/irqArbiter.sv
`timescale 1ns/10ps
`include "ctrl_defines.svh"

module irqArbiter (
    input  logic [`CTRL_NUM_IRQ-1:0] irqReq,
    input  logic                     inIrqEntry,
    output logic                     irqPending,
    output logic [`CTRL_INSTR_W-1:0] irqVector,
    output logic [`CTRL_NUM_IRQ-1:0] irqClr
);

    localparam logic [`CTRL_INSTR_W-1:0] vecTable [`CTRL_NUM_IRQ] = '{
        `CTRL_IRQ_VEC0,
        `CTRL_IRQ_VEC1,
        `CTRL_IRQ_VEC2
    };

    logic [`CTRL_NUM_IRQ-1:0] grant;

    assign irqPending = |irqReq;

    // scan from lowest priority up so request 0 wins
    always_comb begin
        grant     = '0;
        irqVector = '0; // no request
        for (int i = `CTRL_NUM_IRQ - 1; i >= 0; i--) begin
            if (irqReq[i]) begin
                grant     = '0;
                grant[i]  = 1'b1;
                irqVector = vecTable[i];
            end
        end
    end

    assign irqClr = inIrqEntry ? grant : '0; // second entry cycle only

    clrOneHot: assert final ($isunknown(irqClr) || $onehot0(irqClr))
        else $error("more than one interrupt cleared at once");

endmodule

//--- include/ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

//**********************************************************
// datapath widths
`define CTRL_INSTR_W 16

// cycles spent in START before the first fetch
`define CTRL_STARTUP_DELAY 40

//**********************************************************
// interrupt sources and handler addresses
`define CTRL_NUM_IRQ 3
`define CTRL_IRQ_VEC0 20
`define CTRL_IRQ_VEC1 30
`define CTRL_IRQ_VEC2 40

// low byte of the stack pointer pair
`define CTRL_SP_LO_REG 14

`endif

//--- sim.f
+incdir+include
hw/cpuIsaPkg.sv
hw/ctrlSigPkg.sv
hw/instrDecoder.sv
hw/irqArbiter.sv
hw/ctrlSequencer.sv
hw/ctrlDecoder.sv
hw/ctrlTop.sv
dv/ctrlChecker.sv
dv/ctrlTb.sv
